// File: list.f
+incdir+include
src/mul_div_pkg.sv
src/partial_product_mul.sv
src/lane_mul.sv
src/nonrestoring_div.sv
src/mul_div_unit.sv
sim/tb_mul_div_unit.sv

// File: include/mul_div_cases.svh
`ifndef MUL_DIV_CASES_SVH
`define MUL_DIV_CASES_SVH

// one directed test with its expected outputs
typedef struct packed
{
	mul_div_pkg::op_t op;
	mul_div_pkg::int_size_t size;
	logic signedness;
	mul_div_pkg::data_t a;
	mul_div_pkg::data_t b;
	mul_div_pkg::data_t exp_result;
	mul_div_pkg::data_t exp_rem;
} mul_div_case_t;

localparam int NUM_TABLE_CASES = 14;

localparam mul_div_case_t TABLE_CASES [NUM_TABLE_CASES] = '{
	// byte and halfword lanes, carries dropped per lane
	'{mul_div_pkg::OP_MUL, mul_div_pkg::SIZE_8, 1'b0, 64'h1020_ff03_807f_0211,
		64'h1008_ff05_0203_810f, 64'h0000_010f_007d_02ff, 64'h0},
	'{mul_div_pkg::OP_MUL, mul_div_pkg::SIZE_16, 1'b0, 64'h0100_ffff_1234_0003,
		64'h0100_ffff_0010_7fff, 64'h0000_0001_2340_7ffd, 64'h0},
	// two word lanes
	'{mul_div_pkg::OP_MUL, mul_div_pkg::SIZE_32, 1'b0, 64'hffff_ffff_1234_5678,
		64'hffff_ffff_0000_0010, 64'h0000_0001_2345_6780, 64'h0},
	// low half of the full product
	'{mul_div_pkg::OP_MUL, mul_div_pkg::SIZE_64, 1'b0, 64'h0000_0001_0000_0001,
		64'hffff_ffff_ffff_ffff, 64'hffff_fffe_ffff_ffff, 64'h0},
	'{mul_div_pkg::OP_MUL, mul_div_pkg::SIZE_64, 1'b0, 64'h1234_5678_9abc_def0,
		64'h10, 64'h2345_6789_abcd_ef00, 64'h0},
	'{mul_div_pkg::OP_MUL, mul_div_pkg::SIZE_64, 1'b0, 64'h0000_0000_ffff_ffff,
		64'h0000_0000_ffff_ffff, 64'hffff_fffe_0000_0001, 64'h0},
	// unsigned divide
	'{mul_div_pkg::OP_DIV, mul_div_pkg::SIZE_64, 1'b0, 64'd100,
		64'd7, 64'd14, 64'd2},
	'{mul_div_pkg::OP_DIV, mul_div_pkg::SIZE_64, 1'b0, 64'hffff_ffff_ffff_ffff,
		64'h10, 64'h0fff_ffff_ffff_ffff, 64'hf},
	'{mul_div_pkg::OP_DIV, mul_div_pkg::SIZE_64, 1'b0, 64'd5,
		64'd10, 64'd0, 64'd5},
	'{mul_div_pkg::OP_DIV, mul_div_pkg::SIZE_64, 1'b0, 64'h8000_0000_0000_0000,
		64'd3, 64'h2aaa_aaaa_aaaa_aaaa, 64'd2},
	// signed divide, all four sign pairs of 7 and 2
	'{mul_div_pkg::OP_DIV, mul_div_pkg::SIZE_64, 1'b1, 64'd7,
		64'd2, 64'd3, 64'd1},
	'{mul_div_pkg::OP_DIV, mul_div_pkg::SIZE_64, 1'b1, 64'hffff_ffff_ffff_fff9,
		64'd2, 64'hffff_ffff_ffff_fffd, 64'hffff_ffff_ffff_ffff},
	'{mul_div_pkg::OP_DIV, mul_div_pkg::SIZE_64, 1'b1, 64'd7,
		64'hffff_ffff_ffff_fffe, 64'hffff_ffff_ffff_fffd, 64'd1},
	'{mul_div_pkg::OP_DIV, mul_div_pkg::SIZE_64, 1'b1, 64'hffff_ffff_ffff_fff9,
		64'hffff_ffff_ffff_fffe, 64'd3, 64'hffff_ffff_ffff_ffff}
};

`endif

// File: sim/tb_mul_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mul_div_unit;

	`include "mul_div_cases.svh"

	localparam int READY_TIMEOUT = 200;
	localparam int VALID_TIMEOUT = 200;
	localparam int QUIET_CYCLES = 100;

	logic clk;
	logic rst_n;
	mul_div_pkg::unit_cmd_t cmd;
	mul_div_pkg::unit_rsp_t rsp;

	// directed rows followed by random ones
	mul_div_case_t cases[$];
	int errors;
	int tests_run;
	int tests_bad;
	bit timed_out;

	mul_div_unit dut_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd),
		.rsp(rsp)
	);

	always #4 clk = ~clk;

	// each lane of the element size multiplied on its own, carries dropped
	function automatic mul_div_pkg::data_t lane_product(input mul_div_pkg::int_size_t size,
		input mul_div_pkg::data_t a, input mul_div_pkg::data_t b);
		int w;
		mul_div_pkg::data_t mask;
		mul_div_pkg::data_t x;
		mul_div_pkg::data_t y;
		mul_div_pkg::data_t r;
		w = 8 << size;
		mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
		r = '0;
		for (int i = 0; i < 64 / w; i++)
		begin
			x = (a >> (i * w)) & mask;
			y = (b >> (i * w)) & mask;
			r = r | (((x * y) & mask) << (i * w));
		end
		return r;
	endfunction

	// expected values straight from the arithmetic rules
	function automatic mul_div_case_t make_case(input mul_div_pkg::op_t op,
		input mul_div_pkg::int_size_t size, input logic sgn,
		input mul_div_pkg::data_t a, input mul_div_pkg::data_t b);
		mul_div_case_t c;
		c.op = op;
		c.size = size;
		c.signedness = sgn;
		c.a = a;
		c.b = b;
		if (op == mul_div_pkg::OP_MUL)
		begin
			c.exp_result = lane_product(size, a, b);
			c.exp_rem = '0;
		end
		else if (sgn)
		begin
			// truncation toward zero, remainder follows the numerator
			c.exp_result = $signed(a) / $signed(b);
			c.exp_rem = $signed(a) % $signed(b);
		end
		else
		begin
			c.exp_result = a / b;
			c.exp_rem = a % b;
		end
		return c;
	endfunction

	task automatic add_random_cases();
		mul_div_pkg::data_t a;
		mul_div_pkg::data_t b;
		for (int i = 0; i < 4; i++)
		begin
			a = {$urandom, $urandom};
			b = {$urandom, $urandom};
			// sizes 8, 16, 32 and 64
			cases.push_back(make_case(mul_div_pkg::OP_MUL, mul_div_pkg::int_size_t'(i), 1'b0,
				a, b));
		end
		for (int i = 0; i < 2; i++)
		begin
			a = {$urandom, $urandom};
			// short divisor so the quotient has many bits
			b = {32'h0, $urandom | 32'h1};
			cases.push_back(make_case(mul_div_pkg::OP_DIV, mul_div_pkg::SIZE_64, 1'b0, a, b));
		end
		for (int i = 0; i < 4; i++)
		begin
			a = {$urandom, $urandom};
			a[63] = i[0];
			b = ($urandom & 32'hffff) + 64'd1;
			if (i[1])
				b = -b;
			cases.push_back(make_case(mul_div_pkg::OP_DIV, mul_div_pkg::SIZE_64, 1'b1, a, b));
		end
	endtask

	task automatic wait_ready(output bit ok);
		ok = 1'b0;
		for (int n = 0; n < READY_TIMEOUT; n++)
		begin
			@(negedge clk);
			if (rsp.can_accept_cmd)
			begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok)
			$display("timeout at %0t: the DUT never became ready for a command", $time);
	endtask

	task automatic wait_valid(output bit ok, output mul_div_pkg::data_t result,
		output mul_div_pkg::data_t rem);
		ok = 1'b0;
		result = '0;
		rem = '0;
		for (int n = 0; n < VALID_TIMEOUT; n++)
		begin
			@(negedge clk);
			if (rsp.valid)
			begin
				ok = 1'b1;
				result = rsp.result;
				rem = rsp.rem;
				break;
			end
		end
		if (!ok)
			$display("timeout at %0t: no valid came back from the DUT", $time);
	endtask

	// one cycle of enable, then dropped on the next edge
	task automatic send_cmd(input mul_div_case_t c);
		@(posedge clk);
		cmd.enable <= 1'b1;
		cmd.op <= c.op;
		cmd.size <= c.size;
		cmd.signedness <= c.signedness;
		cmd.a <= c.a;
		cmd.b <= c.b;
		@(posedge clk);
		cmd.enable <= 1'b0;
	endtask

	task automatic compare_outputs(input int idx, input mul_div_case_t c,
		input mul_div_pkg::data_t got_result, input mul_div_pkg::data_t got_rem, output bit good);
		good = 1'b1;
		assert (got_result === c.exp_result)
		else
		begin
			$display("** Error at %0t: test %0d result %h, expected %h", $time, idx,
				got_result, c.exp_result);
			errors++;
			good = 1'b0;
		end
		assert (got_rem === c.exp_rem)
		else
		begin
			$display("** Error at %0t: test %0d rem %h, expected %h", $time, idx,
				got_rem, c.exp_rem);
			errors++;
			good = 1'b0;
		end
	endtask

	task automatic run_case(input int idx, input mul_div_case_t c);
		bit ok;
		bit good;
		mul_div_pkg::data_t got_result;
		mul_div_pkg::data_t got_rem;
		wait_ready(ok);
		if (ok)
		begin
			send_cmd(c);
			wait_valid(ok, got_result, got_rem);
		end
		if (!ok)
		begin
			timed_out = 1'b1;
			return;
		end
		compare_outputs(idx, c, got_result, got_rem, good);
		tests_run++;
		if (!good)
			tests_bad++;
		$display("test %0d %s size %0d signed %0b: %s", idx,
			(c.op == mul_div_pkg::OP_DIV) ? "div" : "mul", c.size, c.signedness,
			good ? "ok" : "mismatch");
	endtask

	// second divide while busy must be dropped
	task automatic check_busy_enable(input int idx);
		bit ok;
		bit good;
		int extra;
		mul_div_case_t first;
		mul_div_case_t second;
		mul_div_pkg::data_t got_result;
		mul_div_pkg::data_t got_rem;
		first = make_case(mul_div_pkg::OP_DIV, mul_div_pkg::SIZE_64, 1'b0, 64'd1000, 64'd7);
		second = make_case(mul_div_pkg::OP_DIV, mul_div_pkg::SIZE_64, 1'b0, 64'd999, 64'd5);
		good = 1'b1;
		extra = 0;
		wait_ready(ok);
		if (!ok)
		begin
			timed_out = 1'b1;
			return;
		end
		send_cmd(first);
		repeat (3) @(posedge clk);
		@(negedge clk);
		assert (!rsp.can_accept_cmd)
		else
		begin
			$display("** Error at %0t: test %0d DUT ready during a divide", $time, idx);
			errors++;
			good = 1'b0;
		end
		send_cmd(second);
		wait_valid(ok, got_result, got_rem);
		if (!ok)
		begin
			timed_out = 1'b1;
			return;
		end
		compare_outputs(idx, first, got_result, got_rem, ok);
		good = good && ok;
		// no response may follow for the dropped enable
		repeat (QUIET_CYCLES)
		begin
			@(negedge clk);
			if (rsp.valid)
				extra++;
		end
		assert (extra == 0)
		else
		begin
			$display("** Error at %0t: test %0d %0d extra valid pulses", $time, idx, extra);
			errors++;
			good = 1'b0;
		end
		tests_run++;
		if (!good)
			tests_bad++;
		$display("test %0d enable while busy: %s", idx, good ? "ok" : "mismatch");
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		cmd = '0;
		errors = 0;
		tests_run = 0;
		tests_bad = 0;
		timed_out = 1'b0;
		void'($urandom(32'h950e1265));
		foreach (TABLE_CASES[i])
			cases.push_back(TABLE_CASES[i]);
		add_random_cases();

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		// idle state right after reset
		@(negedge clk);
		assert (rsp.can_accept_cmd === 1'b1 && rsp.valid === 1'b0)
		else
		begin
			$display("** Error at %0t: reset state ready %b valid %b", $time,
				rsp.can_accept_cmd, rsp.valid);
			errors++;
		end
		tests_run++;
		if (errors != 0)
			tests_bad++;
		$display("reset state: %s", (errors == 0) ? "ok" : "mismatch");

		foreach (cases[i])
		begin
			if (!timed_out)
				run_case(i, cases[i]);
		end
		if (!timed_out)
			check_busy_enable(cases.size());

		$display("%0d tests run, %0d mismatching, %0d errors", tests_run, tests_bad, errors);
		if (!timed_out && errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/lane_mul.sv
`timescale 1ns/1ps
`default_nettype none

module lane_mul
(
	input logic clk,
	input logic rst_n,
	input mul_div_pkg::mul_cmd_t cmd,
	output mul_div_pkg::mul_rsp_t rsp
);

	localparam int TW = mul_div_pkg::TINY_WIDTH;
	localparam int SW = mul_div_pkg::SMALL_WIDTH;
	localparam int N8 = mul_div_pkg::DATA_WIDTH / TW;
	localparam int N16 = mul_div_pkg::DATA_WIDTH / SW;

	typedef enum logic
	{
		ST_IDLE,
		ST_WAIT
	} state_t;

	state_t state;
	logic valid;
	logic ready;
	mul_div_pkg::data_t result;
	mul_div_pkg::data_t prod_8;
	mul_div_pkg::data_t prod_16;

	// launch register for the 32/64-bit engine
	mul_div_pkg::mul_cmd_t sub_cmd;
	mul_div_pkg::mul_rsp_t sub_rsp;

	partial_product_mul pp_mul_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.cmd(sub_cmd),
		.rsp(sub_rsp)
	);

	// lane products, truncated to the lane width
	always_comb
	begin
		for (int i = 0; i < N8; i++)
			prod_8[i*TW +: TW] = cmd.a[i*TW +: TW] * cmd.b[i*TW +: TW];
		for (int i = 0; i < N16; i++)
			prod_16[i*SW +: SW] = cmd.a[i*SW +: SW] * cmd.b[i*SW +: SW];
	end

	// both state machines idle before a new command
	assign ready = (state == ST_IDLE) && sub_rsp.can_accept_cmd;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
			valid <= 1'b0;
			result <= '0;
			sub_cmd <= '0;
		end
		else
		begin
			valid <= 1'b0;
			// launch is a single cycle pulse
			sub_cmd.enable <= 1'b0;
			case (state)
			ST_IDLE:
				if (cmd.enable && ready)
				begin
					case (cmd.size)
					mul_div_pkg::SIZE_8:
					begin
						result <= prod_8;
						valid <= 1'b1;
					end
					mul_div_pkg::SIZE_16:
					begin
						result <= prod_16;
						valid <= 1'b1;
					end
					default:
					begin
						// hand off 32 and 64 bit sizes
						state <= ST_WAIT;
						sub_cmd <= cmd;
					end
					endcase
				end
			ST_WAIT:
				if (sub_rsp.valid)
				begin
					state <= ST_IDLE;
					valid <= 1'b1;
					result <= sub_rsp.result;
				end
			default:
				state <= ST_IDLE;
			endcase
		end
	end

	always_comb
	begin
		rsp.can_accept_cmd = ready;
		rsp.valid = valid;
		rsp.result = result;
	end

endmodule

`default_nettype wire

// File: src/mul_div_pkg.sv
`default_nettype none

package mul_div_pkg;

	// lane width and the element widths below it
	localparam int DATA_WIDTH = 64;
	localparam int HALF_WIDTH = 32;
	localparam int SMALL_WIDTH = 16;
	localparam int TINY_WIDTH = 8;

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [HALF_WIDTH-1:0] half_t;
	typedef logic [SMALL_WIDTH-1:0] slice_t;

	// element size codes
	typedef logic [1:0] int_size_t;
	localparam int_size_t SIZE_8 = 2'd0;
	localparam int_size_t SIZE_16 = 2'd1;
	localparam int_size_t SIZE_32 = 2'd2;
	localparam int_size_t SIZE_64 = 2'd3;

	// operation select
	typedef logic op_t;
	localparam op_t OP_MUL = 1'b0;
	localparam op_t OP_DIV = 1'b1;

	// multiplier command and response
	typedef struct packed
	{
		logic enable;
		int_size_t size;
		data_t a;
		data_t b;
	} mul_cmd_t;

	typedef struct packed
	{
		logic can_accept_cmd;
		logic valid;
		data_t result;
	} mul_rsp_t;

	// top level command and response
	typedef struct packed
	{
		logic enable;
		op_t op;
		int_size_t size;
		logic signedness;
		data_t a;
		data_t b;
	} unit_cmd_t;

	// rem is only meaningful for a divide
	typedef struct packed
	{
		logic can_accept_cmd;
		logic valid;
		data_t result;
		data_t rem;
	} unit_rsp_t;

endpackage

`default_nettype wire

// File: src/mul_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_div_unit
(
	input logic clk,
	input logic rst_n,
	input mul_div_pkg::unit_cmd_t cmd,
	output mul_div_pkg::unit_rsp_t rsp
);

	mul_div_pkg::mul_cmd_t mul_cmd;
	mul_div_pkg::mul_rsp_t mul_rsp;
	mul_div_pkg::data_t div_quot, div_rem;
	logic div_enable, div_ready, div_valid;

	// steer by op, each engine checks its own idle state
	always_comb
	begin
		mul_cmd.enable = cmd.enable && (cmd.op == mul_div_pkg::OP_MUL);
		mul_cmd.size = cmd.size;
		mul_cmd.a = cmd.a;
		mul_cmd.b = cmd.b;
		div_enable = cmd.enable && (cmd.op == mul_div_pkg::OP_DIV);
	end

	lane_mul mul_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.cmd(mul_cmd),
		.rsp(mul_rsp)
	);

	nonrestoring_div #(.WIDTH(mul_div_pkg::DATA_WIDTH)) div_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.enable(div_enable),
		.signedness(cmd.signedness),
		.num(cmd.a),
		.denom(cmd.b),
		.quot(div_quot),
		.rem(div_rem),
		.can_accept_cmd(div_ready),
		.valid(div_valid)
	);

	// only one engine is ever busy so the strobes never collide
	always_comb
	begin
		rsp.can_accept_cmd = mul_rsp.can_accept_cmd && div_ready;
		rsp.valid = mul_rsp.valid || div_valid;
		rsp.result = div_valid ? div_quot : mul_rsp.result;
		rsp.rem = div_valid ? div_rem : '0;
	end

endmodule

`default_nettype wire

// File: src/nonrestoring_div.sv
`timescale 1ns/1ps
`default_nettype none

module nonrestoring_div
#(
	parameter int WIDTH = 64
)
(
	input logic clk,
	input logic rst_n,
	input logic enable,
	input logic signedness,
	input logic [WIDTH-1:0] num,
	input logic [WIDTH-1:0] denom,
	output logic [WIDTH-1:0] quot,
	output logic [WIDTH-1:0] rem,
	output logic can_accept_cmd,
	output logic valid
);

	// partial remainder needs one bit over double width for its sign
	localparam int PW = 2 * WIDTH + 1;
	localparam int CW = $clog2(WIDTH);

	typedef enum logic [2:0]
	{
		ST_IDLE,
		ST_FIX,
		ST_ITER,
		ST_CORRECT,
		ST_OUTPUT
	} state_t;

	state_t state;
	logic [CW-1:0] count;

	logic [WIDTH-1:0] num_buf, denom_buf;
	logic [WIDTH-1:0] num_abs, denom_abs;
	logic signed_buf, num_neg, denom_neg;

	// quotient digits, 1 for +1 and 0 for -1
	logic [WIDTH-1:0] q_bits;
	logic [PW-1:0] p, d;

	// magnitudes, only negated for signed operands
	always_comb
	begin
		num_abs = (signed_buf && num_neg) ? -num_buf : num_buf;
		denom_abs = (signed_buf && denom_neg) ? -denom_buf : denom_buf;
	end

	assign can_accept_cmd = (state == ST_IDLE);

	// datapath
	always_ff @(posedge clk)
	begin
		case (state)
		ST_IDLE:
			if (enable)
			begin
				num_buf <= num;
				denom_buf <= denom;
				signed_buf <= signedness;
				num_neg <= num[WIDTH-1];
				denom_neg <= denom[WIDTH-1];
			end
		ST_FIX:
		begin
			p <= PW'(num_abs);
			d <= PW'(denom_abs) << WIDTH;
			q_bits <= '0;
		end
		ST_ITER:
		begin
			// subtract while non-negative, else add back
			q_bits[count] <= ~p[PW-1];
			p <= p[PW-1] ? (p << 1) + d : (p << 1) - d;
		end
		ST_CORRECT:
		begin
			// digits to binary, one step back if left negative
			q_bits <= q_bits - ~q_bits - WIDTH'(p[PW-1]);
			if (p[PW-1])
				p <= p + d;
		end
		default:
			;
		endcase
	end

	// FSM and results
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
			count <= '0;
			valid <= 1'b0;
			quot <= '0;
			rem <= '0;
		end
		else
		begin
			valid <= 1'b0;
			case (state)
			ST_IDLE:
				if (enable)
					state <= ST_FIX;
			ST_FIX:
			begin
				state <= ST_ITER;
				count <= CW'(WIDTH - 1);
			end
			ST_ITER:
			begin
				count <= count - 1'b1;
				if (count == '0)
					state <= ST_CORRECT;
			end
			ST_CORRECT:
				state <= ST_OUTPUT;
			ST_OUTPUT:
			begin
				state <= ST_IDLE;
				valid <= 1'b1;
				// truncate toward zero, remainder follows numerator
				quot <= (signed_buf && (num_neg ^ denom_neg)) ? -q_bits : q_bits;
				rem <= (signed_buf && num_neg) ? -p[WIDTH +: WIDTH] : p[WIDTH +: WIDTH];
			end
			default:
				state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/partial_product_mul.sv
`timescale 1ns/1ps
`default_nettype none

module partial_product_mul
(
	input logic clk,
	input logic rst_n,
	input mul_div_pkg::mul_cmd_t cmd,
	output mul_div_pkg::mul_rsp_t rsp
);

	localparam int DW = mul_div_pkg::DATA_WIDTH;
	localparam int HW = mul_div_pkg::HALF_WIDTH;
	localparam int SW = mul_div_pkg::SMALL_WIDTH;

	typedef enum logic [2:0]
	{
		ST_IDLE,
		ST_MED_ADD,
		ST_LARGE_0,
		ST_LARGE_1,
		ST_LARGE_2,
		ST_LARGE_3
	} state_t;

	state_t state;
	logic valid;
	mul_div_pkg::data_t result;

	// operand slices, slice 0 at the bottom
	mul_div_pkg::slice_t [3:0] a_s;
	mul_div_pkg::slice_t [3:0] b_s;

	// captured partial products, p_i_j is a slice i times b slice j
	mul_div_pkg::half_t p_1_0, p_2_0, p_3_0;
	mul_div_pkg::half_t p_0_1, p_1_1, p_2_1;
	mul_div_pkg::half_t p_0_2, p_1_2, p_0_3;
	// cross terms of the upper 32-bit half
	mul_div_pkg::half_t p_3_2, p_2_3;

	// shifted sums waiting to be added into the result
	mul_div_pkg::data_t t0, t1, t2;

	function automatic mul_div_pkg::half_t mul16(input mul_div_pkg::slice_t x,
		input mul_div_pkg::slice_t y);
		mul16 = mul_div_pkg::half_t'(x) * mul_div_pkg::half_t'(y);
	endfunction

	// zero extend a partial product to the full word
	function automatic mul_div_pkg::data_t ext(input mul_div_pkg::half_t x);
		ext = mul_div_pkg::data_t'(x);
	endfunction

	assign a_s = cmd.a;
	assign b_s = cmd.b;

	// products and temporaries
	always_ff @(posedge clk)
	begin
		case (state)
		ST_IDLE:
			if (cmd.enable)
			begin
				p_1_0 <= mul16(a_s[1], b_s[0]);
				p_2_0 <= mul16(a_s[2], b_s[0]);
				p_3_0 <= mul16(a_s[3], b_s[0]);
				p_0_1 <= mul16(a_s[0], b_s[1]);
				p_1_1 <= mul16(a_s[1], b_s[1]);
				p_2_1 <= mul16(a_s[2], b_s[1]);
				p_0_2 <= mul16(a_s[0], b_s[2]);
				p_1_2 <= mul16(a_s[1], b_s[2]);
				p_0_3 <= mul16(a_s[0], b_s[3]);
				p_3_2 <= mul16(a_s[3], b_s[2]);
				p_2_3 <= mul16(a_s[2], b_s[3]);
			end
		ST_LARGE_0:
		begin
			// one, two and three slices up
			t0 <= (ext(p_1_0) + ext(p_0_1)) << SW;
			t1 <= (ext(p_2_0) + ext(p_1_1)) << (2 * SW);
			t2 <= (ext(p_3_0) + ext(p_2_1)) << (3 * SW);
		end
		ST_LARGE_1:
		begin
			t1 <= t1 + (ext(p_0_2) << (2 * SW));
			t2 <= t2 + (ext(p_1_2) << (3 * SW));
		end
		ST_LARGE_2:
			t2 <= t2 + (ext(p_0_3) << (3 * SW));
		default:
			;
		endcase
	end

	// FSM and result accumulation
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
			valid <= 1'b0;
			result <= '0;
		end
		else
		begin
			valid <= 1'b0;
			case (state)
			ST_IDLE:
				if (cmd.enable)
				begin
					if (cmd.size == mul_div_pkg::SIZE_64)
					begin
						state <= ST_LARGE_0;
						result <= ext(mul16(a_s[0], b_s[0]));
					end
					else
					begin
						// two independent halves
						state <= ST_MED_ADD;
						result <= {mul16(a_s[2], b_s[2]), mul16(a_s[0], b_s[0])};
					end
				end
			ST_MED_ADD:
			begin
				state <= ST_IDLE;
				valid <= 1'b1;
				// cross terms, carries out of each half dropped
				result[HW-1:0] <= result[HW-1:0] + ((p_1_0 + p_0_1) << SW);
				result[DW-1:HW] <= result[DW-1:HW] + ((p_3_2 + p_2_3) << SW);
			end
			ST_LARGE_0:
				state <= ST_LARGE_1;
			ST_LARGE_1:
			begin
				state <= ST_LARGE_2;
				result <= result + t0;
			end
			ST_LARGE_2:
			begin
				state <= ST_LARGE_3;
				result <= result + t1;
			end
			ST_LARGE_3:
			begin
				state <= ST_IDLE;
				valid <= 1'b1;
				result <= result + t2;
			end
			default:
				state <= ST_IDLE;
			endcase
		end
	end

	always_comb
	begin
		rsp.can_accept_cmd = (state == ST_IDLE);
		rsp.valid = valid;
		rsp.result = result;
	end

endmodule

`default_nettype wire
